// File: logic/mipsPipe_cfg.svh
`ifndef MIPS_PIPE_CFG_SVH
`define MIPS_PIPE_CFG_SVH

// core word and register file size
`define MIPS_XLEN 32
`define MIPS_REGS 32

// memory depths in words
`define MIPS_IMEM_WORDS 64
`define MIPS_DMEM_WORDS 64

// --------------------
// apb address map
`define MIPS_APB_AW 12
`define MIPS_APB_IMEM_BASE 12'h000
`define MIPS_APB_DMEM_BASE 12'h100
// bit 0 write starts the core
`define MIPS_APB_CTRL 12'h200
// bit 0 running and bit 1 done
`define MIPS_APB_STATUS 12'h204

`endif

// File: logic/isaPkg.sv
package isaPkg;

  typedef logic [5:0] opcodeT;
  typedef logic [5:0] functT;
  typedef logic [4:0] regIdxT;

  // r-type layout
  // i and j formats reuse the low bits
  typedef struct packed {
    opcodeT     opcode;
    regIdxT     rs;
    regIdxT     rt;
    regIdxT     rd;
    logic [4:0] shamt;
    functT      funct;
  } instrT;

  // --------------------
  // opcodes
  localparam opcodeT opRType = 6'h00;
  localparam opcodeT opJ     = 6'h02;
  localparam opcodeT opBeq   = 6'h04;
  localparam opcodeT opAddi  = 6'h08;
  localparam opcodeT opLw    = 6'h23;
  localparam opcodeT opSw    = 6'h2b;
  // all ones ends a program
  localparam opcodeT opHalt  = 6'h3f;

  // r-type funct codes
  localparam functT fnAdd = 6'h20;
  localparam functT fnSub = 6'h22;
  localparam functT fnAnd = 6'h24;
  localparam functT fnOr  = 6'h25;
  localparam functT fnSlt = 6'h2a;

  typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOpT;

  // decoded control for one instruction
  typedef struct packed {
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  memToReg;
    logic  aluSrc;
    logic  regDstRd;
    aluOpT aluOp;
    logic  branch;
    logic  jump;
    logic  halt;
  } ctrlT;

  // i-type immediate field
  function automatic logic [15:0] immOf(instrT instr);
    return instr[15:0];
  endfunction

  // j-type word index
  function automatic logic [25:0] jIdxOf(instrT instr);
    return instr[25:0];
  endfunction

endpackage

// File: logic/pipePkg.sv
`include "mipsPipe_cfg.svh"

package pipePkg;

  typedef logic [`MIPS_XLEN-1:0] wordT;

  // operand source for the forwarding muxes
  typedef enum logic [1:0] {fwdRegFile, fwdExMem, fwdMemWb} fwdSelT;

  // --------------------
  // stage payloads
  typedef struct packed {
    logic          valid;
    wordT          pcPlus4;
    isaPkg::instrT instr;
  } ifIdT;

  typedef struct packed {
    logic           valid;
    isaPkg::ctrlT   ctrl;
    wordT           pcPlus4;
    wordT           rsData;
    wordT           rtData;
    wordT           imm;
    isaPkg::regIdxT rs;
    isaPkg::regIdxT rt;
    isaPkg::regIdxT rd;
  } idExT;

  // only the control bits still needed past execute
  typedef struct packed {
    logic           valid;
    logic           regWrite;
    logic           memRead;
    logic           memWrite;
    logic           memToReg;
    logic           halt;
    wordT           aluResult;
    wordT           storeData;
    isaPkg::regIdxT dest;
  } exMemT;

  typedef struct packed {
    logic           valid;
    logic           regWrite;
    logic           memToReg;
    logic           halt;
    wordT           aluResult;
    wordT           loadData;
    isaPkg::regIdxT dest;
  } memWbT;

  // --------------------
  // apb slave port
  typedef struct packed {
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`MIPS_APB_AW-1:0] paddr;
    wordT                    pwdata;
  } apbReqT;

  typedef struct packed {
    logic pready;
    logic pslverr;
    wordT prdata;
  } apbRspT;

endpackage

// File: logic/stageReg.sv
`timescale 1ns/1ps

module stageReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    hold,
  input  logic    flush,
  input  payloadT d,
  output payloadT q
);

  // flush beats hold
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps
`include "mipsPipe_cfg.svh"

module regFile (
  input  logic           clk,
  input  logic           rstN,
  input  isaPkg::regIdxT rdIdxA,
  input  isaPkg::regIdxT rdIdxB,
  output pipePkg::wordT  rdDataA,
  output pipePkg::wordT  rdDataB,
  input  logic           wrEn,
  input  isaPkg::regIdxT wrIdx,
  input  pipePkg::wordT  wrData
);
  import pipePkg::*;

  wordT regs [`MIPS_REGS];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regs <= '{default: '0};
    end else if (wrEn && wrIdx != '0) begin
      regs[wrIdx] <= wrData;
    end
  end

  // r0 reads zero
  // writeback data bypasses the array in the same cycle
  assign rdDataA = (rdIdxA == '0) ? '0 :
                   (wrEn && wrIdx == rdIdxA) ? wrData : regs[rdIdxA];
  assign rdDataB = (rdIdxB == '0) ? '0 :
                   (wrEn && wrIdx == rdIdxB) ? wrData : regs[rdIdxB];

endmodule

// File: logic/execUnit.sv
`timescale 1ns/1ps

module execUnit (
  input  pipePkg::idExT   idExStage,
  input  pipePkg::fwdSelT exFwdA,
  input  pipePkg::fwdSelT exFwdB,
  input  pipePkg::wordT   exMemResult,
  input  pipePkg::wordT   wbData,
  output pipePkg::exMemT  exMemNext
);
  import isaPkg::*;
  import pipePkg::*;

  wordT opA;
  wordT rtVal;
  wordT opB;
  wordT aluResult;

  // --------------------
  // operand forwarding
  always_comb begin
    case (exFwdA)
      fwdExMem: opA = exMemResult;
      fwdMemWb: opA = wbData;
      default:  opA = idExStage.rsData;
    endcase
    case (exFwdB)
      fwdExMem: rtVal = exMemResult;
      fwdMemWb: rtVal = wbData;
      default:  rtVal = idExStage.rtData;
    endcase
  end

  // immediate for addi lw sw
  assign opB = idExStage.ctrl.aluSrc ? idExStage.imm : rtVal;

  always_comb begin
    case (idExStage.ctrl.aluOp)
      aluSub:  aluResult = opA - opB;
      aluAnd:  aluResult = opA & opB;
      aluOr:   aluResult = opA | opB;
      // signed compare
      aluSlt:  aluResult = wordT'($signed(opA) < $signed(opB));
      default: aluResult = opA + opB;
    endcase
  end

  // --------------------
  // ex/mem payload
  always_comb begin
    exMemNext.valid     = idExStage.valid;
    exMemNext.regWrite  = idExStage.ctrl.regWrite;
    exMemNext.memRead   = idExStage.ctrl.memRead;
    exMemNext.memWrite  = idExStage.ctrl.memWrite;
    exMemNext.memToReg  = idExStage.ctrl.memToReg;
    exMemNext.halt      = idExStage.ctrl.halt;
    exMemNext.aluResult = aluResult;
    // sw data must see forwarded rt too
    exMemNext.storeData = rtVal;
    exMemNext.dest      = idExStage.ctrl.regDstRd ? idExStage.rd : idExStage.rt;
  end

endmodule

// File: logic/wordMem.sv
`timescale 1ns/1ps

module wordMem #(
  parameter int depth = 64
) (
  input  logic          clk,
  input  pipePkg::wordT coreAddr,
  input  logic          coreWrEn,
  input  pipePkg::wordT coreWrData,
  output pipePkg::wordT coreRdData,
  input  pipePkg::wordT hostAddr,
  input  logic          hostWrEn,
  input  pipePkg::wordT hostWrData,
  output pipePkg::wordT hostRdData
);
  import pipePkg::*;

  localparam int idxW = $clog2(depth);

  wordT            mem [depth];
  logic [idxW-1:0] coreIdx;
  logic [idxW-1:0] hostIdx;

  // byte addresses in, word index out
  assign coreIdx = coreAddr[idxW+1:2];
  assign hostIdx = hostAddr[idxW+1:2];

  always_ff @(posedge clk) begin
    if (hostWrEn) begin
      mem[hostIdx] <= hostWrData;
    end else if (coreWrEn) begin
      mem[coreIdx] <= coreWrData;
    end
  end

  // combinational reads
  assign coreRdData = mem[coreIdx];
  assign hostRdData = mem[hostIdx];

endmodule

// File: logic/apbHost.sv
`timescale 1ns/1ps
`include "mipsPipe_cfg.svh"

module apbHost (
  input  logic            clk,
  input  logic            rstN,
  input  pipePkg::apbReqT apbReq,
  output pipePkg::apbRspT apbRsp,
  input  logic            running,
  input  logic            done,
  output logic            start,
  output logic            imemWrEn,
  output logic            dmemWrEn,
  output pipePkg::wordT   hostAddr,
  output pipePkg::wordT   hostWrData,
  input  pipePkg::wordT   dmemRdData
);
  import pipePkg::*;

  // window ends
  localparam logic [`MIPS_APB_AW-1:0] imemTop = `MIPS_APB_IMEM_BASE + `MIPS_IMEM_WORDS * 4;
  localparam logic [`MIPS_APB_AW-1:0] dmemTop = `MIPS_APB_DMEM_BASE + `MIPS_DMEM_WORDS * 4;

  logic access;
  logic inImem;
  logic inDmem;
  logic isCtrl;
  logic isStatus;
  logic busy;

  // --------------------
  // address decode
  assign access   = apbReq.psel && apbReq.penable;
  assign inImem   = apbReq.paddr >= `MIPS_APB_IMEM_BASE && apbReq.paddr < imemTop;
  assign inDmem   = apbReq.paddr >= `MIPS_APB_DMEM_BASE && apbReq.paddr < dmemTop;
  assign isCtrl   = apbReq.paddr == `MIPS_APB_CTRL;
  assign isStatus = apbReq.paddr == `MIPS_APB_STATUS;
  // memories belong to the core while it runs
  assign busy     = running && (inImem || inDmem);

  assign imemWrEn   = access && apbReq.pwrite && inImem && !running;
  assign dmemWrEn   = access && apbReq.pwrite && inDmem && !running;
  // offset inside the selected window
  assign hostAddr   = wordT'(apbReq.paddr
                      - (inDmem ? `MIPS_APB_DMEM_BASE : `MIPS_APB_IMEM_BASE));
  assign hostWrData = apbReq.pwdata;

  // one cycle start after a ctrl write while idle
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      start <= 1'b0;
    end else begin
      start <= access && apbReq.pwrite && isCtrl && apbReq.pwdata[0] && !running;
    end
  end

  // --------------------
  // response with zero wait states
  always_comb begin
    apbRsp.pready  = 1'b1;
    apbRsp.pslverr = access && (!(inImem || inDmem || isCtrl || isStatus) || busy);
    apbRsp.prdata  = '0;
    if (access && !apbReq.pwrite) begin
      if (inDmem && !running) begin
        apbRsp.prdata = dmemRdData;
      end else if (isStatus) begin
        apbRsp.prdata = wordT'({done, running});
      end
    end
  end

endmodule

// File: logic/pipeControl.sv
`timescale 1ns/1ps

module pipeControl (
  input  logic            clk,
  input  logic            rstN,
  input  logic            start,
  input  isaPkg::instrT   ifIdInstr,
  input  pipePkg::idExT   idExStage,
  input  pipePkg::exMemT  exMemStage,
  input  pipePkg::memWbT  memWbStage,
  input  logic            branchTaken,
  output isaPkg::ctrlT    ctrl,
  output logic            pcWrite,
  output logic            ifIdHold,
  output logic            ifIdFlush,
  output logic            idExFlush,
  output pipePkg::fwdSelT idFwdA,
  output pipePkg::fwdSelT idFwdB,
  output pipePkg::fwdSelT exFwdA,
  output pipePkg::fwdSelT exFwdB,
  output logic            running,
  output logic            done
);
  import isaPkg::*;
  import pipePkg::*;

  logic   usesRs;
  logic   usesRt;
  regIdxT exDest;
  logic   exHit;
  logic   memLoadHit;
  logic   stall;
  logic   haltPending;

  // newest producer wins, r0 never forwards
  function automatic fwdSelT pickFwd(regIdxT src, exMemT em, memWbT mw);
    if (em.regWrite && em.dest != '0 && em.dest == src) return fwdExMem;
    if (mw.regWrite && mw.dest != '0 && mw.dest == src) return fwdMemWb;
    return fwdRegFile;
  endfunction

  // does the decode instruction read register d
  function automatic logic idReads(regIdxT d, instrT ins, logic readsRs, logic readsRt);
    return d != '0 && ((readsRs && d == ins.rs) || (readsRt && d == ins.rt));
  endfunction

  // --------------------
  // decode
  always_comb begin
    ctrl = '0;
    case (ifIdInstr.opcode)
      opRType: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDstRd = 1'b1;
        case (ifIdInstr.funct)
          fnAdd:   ctrl.aluOp = aluAdd;
          fnSub:   ctrl.aluOp = aluSub;
          fnAnd:   ctrl.aluOp = aluAnd;
          fnOr:    ctrl.aluOp = aluOr;
          fnSlt:   ctrl.aluOp = aluSlt;
          // unknown funct behaves as a nop
          default: ctrl = '0;
        endcase
      end
      opAddi: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
      end
      opLw: begin
        ctrl.regWrite = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluSrc   = 1'b1;
      end
      opSw: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
      end
      opBeq:   ctrl.branch = 1'b1;
      opJ:     ctrl.jump = 1'b1;
      opHalt:  ctrl.halt = 1'b1;
      default: ctrl = '0;
    endcase
  end

  // which source fields are real operands
  assign usesRt = (ctrl.regWrite && ctrl.regDstRd) || ctrl.memWrite || ctrl.branch;
  assign usesRs = usesRt || ctrl.aluSrc;

  // --------------------
  // hazards
  assign exDest     = idExStage.ctrl.regDstRd ? idExStage.rd : idExStage.rt;
  assign exHit      = idExStage.ctrl.regWrite && idReads(exDest, ifIdInstr, usesRs, usesRt);
  assign memLoadHit = exMemStage.memRead
                      && idReads(exMemStage.dest, ifIdInstr, usesRs, usesRt);

  // load-use, or beq waiting on a result not yet in ex/mem
  assign stall = (idExStage.ctrl.memRead && exHit) || (ctrl.branch && (exHit || memLoadHit));

  // halt anywhere ahead of writeback freezes fetch
  assign haltPending = ctrl.halt || idExStage.ctrl.halt || exMemStage.halt || memWbStage.halt;

  assign pcWrite   = running && !stall && !haltPending;
  assign ifIdHold  = stall;
  assign ifIdFlush = !running || (!stall && (haltPending || branchTaken || ctrl.jump));
  // bubble into execute while decode waits
  assign idExFlush = stall;

  // --------------------
  // forwarding
  assign idFwdA = pickFwd(ifIdInstr.rs, exMemStage, memWbStage);
  assign idFwdB = pickFwd(ifIdInstr.rt, exMemStage, memWbStage);
  assign exFwdA = pickFwd(idExStage.rs, exMemStage, memWbStage);
  assign exFwdB = pickFwd(idExStage.rt, exMemStage, memWbStage);

  // run state
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      running <= 1'b0;
      done    <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
      done    <= 1'b0;
    end else if (running && memWbStage.valid && memWbStage.halt) begin
      // halt retired
      running <= 1'b0;
      done    <= 1'b1;
    end
  end

endmodule

// File: logic/mipsPipe.sv
`timescale 1ns/1ps
`include "mipsPipe_cfg.svh"

module mipsPipe (
  input  logic            clk,
  input  logic            rstN,
  input  pipePkg::apbReqT apbReq,
  output pipePkg::apbRspT apbRsp
);
  import isaPkg::*;
  import pipePkg::*;

  wordT        pc;
  wordT        pcPlus4;
  wordT        nextPc;
  wordT        imemRd;
  ifIdT        ifIdD;
  ifIdT        ifIdQ;
  idExT        idExD;
  idExT        idExQ;
  exMemT       exMemD;
  exMemT       exMemQ;
  memWbT       memWbD;
  memWbT       memWbQ;
  ctrlT        ctrl;
  fwdSelT      idFwdA;
  fwdSelT      idFwdB;
  fwdSelT      exFwdA;
  fwdSelT      exFwdB;
  logic        pcWrite;
  logic        ifIdHold;
  logic        ifIdFlush;
  logic        idExFlush;
  logic        branchTaken;
  logic        start;
  logic        running;
  logic        done;
  logic        imemWrEn;
  logic        dmemWrEn;
  logic [15:0] imm16;
  wordT        imm;
  wordT        rsData;
  wordT        rtData;
  wordT        idOpA;
  wordT        idOpB;
  wordT        branchTarget;
  wordT        jumpTarget;
  wordT        wbData;
  wordT        loadData;
  wordT        hostAddr;
  wordT        hostWrData;
  wordT        dmemHostRd;

  // --------------------
  // fetch
  assign pcPlus4 = pc + 32'd4;
  // jump first, then taken beq
  assign nextPc  = ctrl.jump ? jumpTarget : branchTaken ? branchTarget : pcPlus4;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
    end else if (start) begin
      // every run begins at word 0
      pc <= '0;
    end else if (pcWrite) begin
      pc <= nextPc;
    end
  end

  assign ifIdD = '{valid: 1'b1, pcPlus4: pcPlus4, instr: instrT'(imemRd)};

  stageReg #(.payloadT(ifIdT)) i_ifIdReg (
    .clk(clk), .rstN(rstN), .hold(ifIdHold), .flush(ifIdFlush), .d(ifIdD), .q(ifIdQ)
  );

  // --------------------
  // decode
  assign imm16        = immOf(ifIdQ.instr);
  assign imm          = {{(`MIPS_XLEN-16){imm16[15]}}, imm16};
  assign branchTarget = ifIdQ.pcPlus4 + (imm << 2);
  assign jumpTarget   = {ifIdQ.pcPlus4[`MIPS_XLEN-1:28], jIdxOf(ifIdQ.instr), 2'b00};

  // beq compares forwarded operands
  always_comb begin
    case (idFwdA)
      fwdExMem: idOpA = exMemQ.aluResult;
      fwdMemWb: idOpA = wbData;
      default:  idOpA = rsData;
    endcase
    case (idFwdB)
      fwdExMem: idOpB = exMemQ.aluResult;
      fwdMemWb: idOpB = wbData;
      default:  idOpB = rtData;
    endcase
  end

  assign branchTaken = ctrl.branch && (idOpA == idOpB);

  pipeControl i_pipeControl (
    .clk(clk), .rstN(rstN), .start(start), .ifIdInstr(ifIdQ.instr),
    .idExStage(idExQ), .exMemStage(exMemQ), .memWbStage(memWbQ),
    .branchTaken(branchTaken), .ctrl(ctrl), .pcWrite(pcWrite),
    .ifIdHold(ifIdHold), .ifIdFlush(ifIdFlush), .idExFlush(idExFlush),
    .idFwdA(idFwdA), .idFwdB(idFwdB), .exFwdA(exFwdA), .exFwdB(exFwdB),
    .running(running), .done(done)
  );

  regFile i_regFile (
    .clk(clk), .rstN(rstN), .rdIdxA(ifIdQ.instr.rs), .rdIdxB(ifIdQ.instr.rt),
    .rdDataA(rsData), .rdDataB(rtData),
    .wrEn(memWbQ.regWrite), .wrIdx(memWbQ.dest), .wrData(wbData)
  );

  assign idExD = '{valid: ifIdQ.valid, ctrl: ctrl, pcPlus4: ifIdQ.pcPlus4,
                   rsData: rsData, rtData: rtData, imm: imm,
                   rs: ifIdQ.instr.rs, rt: ifIdQ.instr.rt, rd: ifIdQ.instr.rd};

  stageReg #(.payloadT(idExT)) i_idExReg (
    .clk(clk), .rstN(rstN), .hold(1'b0), .flush(idExFlush), .d(idExD), .q(idExQ)
  );

  // --------------------
  // execute
  execUnit i_execUnit (
    .idExStage(idExQ), .exFwdA(exFwdA), .exFwdB(exFwdB),
    .exMemResult(exMemQ.aluResult), .wbData(wbData), .exMemNext(exMemD)
  );

  stageReg #(.payloadT(exMemT)) i_exMemReg (
    .clk(clk), .rstN(rstN), .hold(1'b0), .flush(1'b0), .d(exMemD), .q(exMemQ)
  );

  // --------------------
  // memory
  assign memWbD = '{valid: exMemQ.valid, regWrite: exMemQ.regWrite,
                    memToReg: exMemQ.memToReg, halt: exMemQ.halt,
                    aluResult: exMemQ.aluResult, loadData: loadData, dest: exMemQ.dest};

  stageReg #(.payloadT(memWbT)) i_memWbReg (
    .clk(clk), .rstN(rstN), .hold(1'b0), .flush(1'b0), .d(memWbD), .q(memWbQ)
  );

  // writeback
  assign wbData = memWbQ.memToReg ? memWbQ.loadData : memWbQ.aluResult;

  // --------------------
  // memories and host port
  wordMem #(.depth(`MIPS_IMEM_WORDS)) i_imem (
    .clk(clk), .coreAddr(pc), .coreWrEn(1'b0), .coreWrData('0), .coreRdData(imemRd),
    .hostAddr(hostAddr), .hostWrEn(imemWrEn), .hostWrData(hostWrData), .hostRdData()
  );

  wordMem #(.depth(`MIPS_DMEM_WORDS)) i_dmem (
    .clk(clk), .coreAddr(exMemQ.aluResult), .coreWrEn(exMemQ.memWrite),
    .coreWrData(exMemQ.storeData), .coreRdData(loadData),
    .hostAddr(hostAddr), .hostWrEn(dmemWrEn), .hostWrData(hostWrData),
    .hostRdData(dmemHostRd)
  );

  apbHost i_apbHost (
    .clk(clk), .rstN(rstN), .apbReq(apbReq), .apbRsp(apbRsp),
    .running(running), .done(done), .start(start),
    .imemWrEn(imemWrEn), .dmemWrEn(dmemWrEn),
    .hostAddr(hostAddr), .hostWrData(hostWrData), .dmemRdData(dmemHostRd)
  );

endmodule

// File: testbench/mipsPipe_props.sv
`timescale 1ns/1ps

module mipsPipeProps (
  input logic            clk,
  input logic            rstN,
  input pipePkg::apbReqT apbReq,
  input pipePkg::apbRspT apbRsp,
  input logic            start,
  input logic            running,
  input logic            done,
  input logic            pcWrite,
  input logic            ifIdHold,
  input logic            haltInPipe
);

  // --------------------
  // apb response only in the access phase
  apbRspQuiet: assert property (@(posedge clk) disable iff (!rstN)
    !(apbReq.psel && apbReq.penable) |-> (!apbRsp.pslverr && apbRsp.prdata == '0))
    else $error("apb response active outside the access phase");

  // run flags exclusive
  runDoneExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(running && done))
    else $error("running and done both high");

  // --------------------
  // a frozen pc with no halt ahead means a stall
  stallHoldsIfId: assert property (@(posedge clk) disable iff (!rstN)
    (running && !pcWrite && !haltInPipe) |-> ifIdHold)
    else $error("pc frozen without holding if/id");

  // idle core only wakes on start
  idleUntilStart: assert property (@(posedge clk) disable iff (!rstN)
    (!running && !start) |=> !running)
    else $error("core began running without a start pulse");

endmodule

bind mipsPipe mipsPipeProps i_mipsPipeProps (
  .clk(clk), .rstN(rstN), .apbReq(apbReq), .apbRsp(apbRsp),
  .start(start), .running(running), .done(done),
  .pcWrite(pcWrite), .ifIdHold(ifIdHold),
  .haltInPipe(ctrl.halt || idExQ.ctrl.halt || exMemQ.halt || memWbQ.halt)
);

// File: testbench/mipsPipe_tb.sv
`timescale 1ns/1ps
`include "mipsPipe_cfg.svh"

module mipsPipeTb;
  import pipePkg::*;

  localparam int clkPeriod     = 8;
  localparam int resetCycles   = 4;
  localparam int numRows       = 7;
  // each row plus the apb map section gets 200 cycles
  localparam int timeoutCycles = (numRows + 1) * 200 + resetCycles;

  // encodings
  localparam logic [5:0]  opAddi   = 6'h08;
  localparam logic [5:0]  opLw     = 6'h23;
  localparam logic [5:0]  opSw     = 6'h2b;
  localparam logic [5:0]  opBeq    = 6'h04;
  localparam logic [5:0]  fnAdd    = 6'h20;
  localparam logic [5:0]  fnSub    = 6'h22;
  localparam logic [5:0]  fnAnd    = 6'h24;
  localparam logic [5:0]  fnOr     = 6'h25;
  localparam logic [5:0]  fnSlt    = 6'h2a;
  localparam logic [31:0] haltWord = 32'hfc00_0000;

  logic        clk;
  logic        rstN;
  apbReqT      apbReq;
  apbRspT      apbRsp;
  logic [31:0] lfsrState;

  // program table
  string       rowName [numRows];
  logic [31:0] rowProg [numRows][8];
  logic [7:0]  rowAddr [numRows];
  logic [31:0] rowExp  [numRows];

  mipsPipe i_mipsPipe (.clk(clk), .rstN(rstN), .apbReq(apbReq), .apbRsp(apbRsp));

  always #(clkPeriod / 2) clk = ~clk;

  // --------------------
  // instruction builders
  function automatic logic [31:0] rType(logic [5:0] funct, logic [4:0] rd, logic [4:0] rs,
                                        logic [4:0] rt);
    return {6'h00, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rt, logic [4:0] rs,
                                        logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jumpTo(logic [25:0] wordIdx);
    return {6'h02, wordIdx};
  endfunction

  function automatic logic [31:0] signExt(logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  // sentinel seen where no store may land
  function automatic logic [31:0] fillWord(logic [7:0] addr);
    return {8'ha5, addr, ~addr, 8'h5a};
  endfunction

  // galois lfsr shifting right
  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit
  function automatic logic [15:0] randImm();
    logic [15:0] bits;
    for (int i = 0; i < 16; i++) begin
      lfsrState = lfsrNext(lfsrState);
      bits[i]   = lfsrState[0];
    end
    return bits;
  endfunction

  task automatic checkValue(string name, logic [31:0] expVal, logic [31:0] actVal);
    if (expVal !== actVal) begin
      $display("ERR %s expected %h actual %h", name, expVal, actVal);
      $display("ERRORS FOUND");
      $fatal(1, "value mismatch");
    end
  endtask

  // --------------------
  // apb transfer driven on the falling edge
  task automatic apbXfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                         output logic [31:0] rdata, output logic err);
    @(negedge clk);
    apbReq.psel    = 1'b1;
    apbReq.penable = 1'b0;
    apbReq.pwrite  = wr;
    apbReq.paddr   = addr;
    apbReq.pwdata  = wdata;
    @(negedge clk);
    apbReq.penable = 1'b1;
    // sample mid low phase
    #(clkPeriod / 4);
    while (!apbRsp.pready) begin
      @(negedge clk);
      #(clkPeriod / 4);
    end
    rdata = apbRsp.prdata;
    err   = apbRsp.pslverr;
    @(negedge clk);
    apbReq.psel    = 1'b0;
    apbReq.penable = 1'b0;
  endtask

  task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    logic        err;
    apbXfer(1'b1, addr, data, unused, err);
    checkValue($sformatf("pslverr on write %h", addr), 32'h0, {31'd0, err});
  endtask

  task automatic apbRead(input logic [11:0] addr, output logic [31:0] data);
    logic err;
    apbXfer(1'b0, addr, '0, data, err);
    checkValue($sformatf("pslverr on read %h", addr), 32'h0, {31'd0, err});
  endtask

  // poll status until done
  task automatic waitDone();
    logic [31:0] status;
    status = '0;
    while (!status[1]) begin
      apbRead(`MIPS_APB_STATUS, status);
    end
  endtask

  // --------------------
  task automatic buildTable();
    logic [15:0] a;
    logic [15:0] b;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [31:0] r5;
    for (int r = 0; r < numRows; r++) begin
      for (int i = 0; i < 8; i++) begin
        rowProg[r][i] = haltWord;
      end
    end
    // dependent chain through ex/mem and mem/wb
    a = randImm();
    b = randImm();
    rowName[0] = "arith";
    rowProg[0][0] = iType(opAddi, 1, 0, a);
    rowProg[0][1] = iType(opAddi, 2, 1, b);
    rowProg[0][2] = rType(fnAdd, 3, 1, 2);
    rowProg[0][3] = rType(fnSub, 4, 3, 1);
    rowProg[0][4] = rType(fnAnd, 5, 4, 3);
    rowProg[0][5] = rType(fnOr, 6, 5, 1);
    rowProg[0][6] = iType(opSw, 6, 0, 16'h0000);
    r1 = signExt(a);
    r2 = r1 + signExt(b);
    r3 = r1 + r2;
    r4 = r3 - r1;
    r5 = r4 & r3;
    rowAddr[0] = 8'h00;
    rowExp[0]  = r5 | r1;
    // signed compare both ways
    a = randImm();
    b = randImm();
    rowName[1] = "slt";
    rowProg[1][0] = iType(opAddi, 1, 0, a);
    rowProg[1][1] = iType(opAddi, 2, 0, b);
    rowProg[1][2] = rType(fnSlt, 3, 1, 2);
    rowProg[1][3] = rType(fnSlt, 4, 2, 1);
    rowProg[1][4] = rType(fnAdd, 4, 4, 4);
    rowProg[1][5] = rType(fnOr, 5, 3, 4);
    rowProg[1][6] = iType(opSw, 5, 0, 16'h0004);
    rowAddr[1] = 8'h04;
    rowExp[1]  = 32'h0;
    if ($signed(signExt(a)) < $signed(signExt(b))) rowExp[1] = 32'h1;
    if ($signed(signExt(b)) < $signed(signExt(a))) rowExp[1] = rowExp[1] + 32'h2;
    // add right behind its load
    rowName[2] = "loadUse";
    rowProg[2][0] = iType(opAddi, 1, 0, 16'h1234);
    rowProg[2][1] = iType(opAddi, 4, 0, 16'h0042);
    rowProg[2][2] = iType(opSw, 1, 0, 16'h0010);
    rowProg[2][3] = iType(opLw, 2, 0, 16'h0010);
    rowProg[2][4] = rType(fnAdd, 3, 2, 4);
    rowProg[2][5] = iType(opSw, 3, 0, 16'h0014);
    rowAddr[2] = 8'h14;
    rowExp[2]  = signExt(16'h1234) + signExt(16'h0042);
    // taken beq skips two stores
    rowName[3] = "beqTaken";
    rowProg[3][0] = iType(opAddi, 1, 0, 16'h0007);
    rowProg[3][1] = iType(opAddi, 2, 0, 16'h0007);
    rowProg[3][2] = iType(opBeq, 2, 1, 16'h0002);
    rowProg[3][3] = iType(opSw, 1, 0, 16'h0020);
    rowProg[3][4] = iType(opSw, 1, 0, 16'h0020);
    rowAddr[3] = 8'h20;
    rowExp[3]  = fillWord(8'h20);
    // beq on a fresh load falls through
    rowName[4] = "beqNotTaken";
    rowProg[4][0] = iType(opAddi, 1, 0, 16'h0003);
    rowProg[4][1] = iType(opSw, 1, 0, 16'h0024);
    rowProg[4][2] = iType(opLw, 2, 0, 16'h0024);
    rowProg[4][3] = iType(opBeq, 0, 2, 16'h0001);
    rowProg[4][4] = iType(opSw, 2, 0, 16'h0028);
    rowAddr[4] = 8'h28;
    rowExp[4]  = 32'h3;
    // same jump program checked at two addresses
    for (int r = 5; r < 7; r++) begin
      rowProg[r][0] = iType(opAddi, 1, 0, 16'h0009);
      rowProg[r][1] = jumpTo(26'd3);
      rowProg[r][2] = iType(opSw, 1, 0, 16'h002c);
      rowProg[r][3] = iType(opSw, 1, 0, 16'h0030);
    end
    rowName[5] = "jumpSkip";
    rowAddr[5] = 8'h2c;
    rowExp[5]  = fillWord(8'h2c);
    rowName[6] = "jumpLand";
    rowAddr[6] = 8'h30;
    rowExp[6]  = 32'h9;
  endtask

  // load, run to done, check status and one word
  task automatic runRow(int r);
    logic [31:0] data;
    logic [11:0] addr;
    for (int i = 0; i < 8; i++) begin
      apbWrite(`MIPS_APB_IMEM_BASE + 12'(i * 4), rowProg[r][i]);
    end
    addr = `MIPS_APB_DMEM_BASE + {4'h0, rowAddr[r]};
    apbWrite(addr, fillWord(rowAddr[r]));
    apbWrite(`MIPS_APB_CTRL, 32'h1);
    waitDone();
    apbRead(`MIPS_APB_STATUS, data);
    checkValue({rowName[r], " status"}, 32'h2, data);
    apbRead(addr, data);
    checkValue(rowName[r], rowExp[r], data);
  endtask

  // --------------------
  task automatic checkApbMap();
    logic [31:0] data;
    logic        err;
    apbWrite(`MIPS_APB_DMEM_BASE + 12'h0fc, 32'h1357_9bdf);
    apbRead(`MIPS_APB_DMEM_BASE + 12'h0fc, data);
    checkValue("apbMap dmem readback", 32'h1357_9bdf, data);
    // done left over from the last row
    apbRead(`MIPS_APB_STATUS, data);
    checkValue("apbMap idle status", 32'h2, data);
    apbXfer(1'b0, 12'h300, '0, data, err);
    checkValue("apbMap unmapped pslverr", 32'h1, {31'd0, err});
    // imem is locked while the core runs
    apbWrite(`MIPS_APB_CTRL, 32'h1);
    apbXfer(1'b1, `MIPS_APB_IMEM_BASE, haltWord, data, err);
    checkValue("apbMap imem busy pslverr", 32'h1, {31'd0, err});
    waitDone();
    apbRead(`MIPS_APB_STATUS, data);
    checkValue("apbMap final status", 32'h2, data);
  endtask

  initial begin : mainSeq
    clk       = 1'b0;
    rstN      = 1'b0;
    apbReq    = '0;
    lfsrState = 32'hdcf2;
    buildTable();
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    for (int r = 0; r < numRows; r++) begin
      runRow(r);
    end
    checkApbMap();
    $display("NO ERRORS");
    $finish;
  end

  // hang guard
  initial begin : watchdog
    repeat (timeoutCycles) @(posedge clk);
    $display("timeout, the core or the bus did not finish in time");
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: mipsPipe.f
+incdir+logic
logic/isaPkg.sv
logic/pipePkg.sv
logic/stageReg.sv
logic/regFile.sv
logic/execUnit.sv
logic/wordMem.sv
logic/apbHost.sv
logic/pipeControl.sv
logic/mipsPipe.sv
testbench/mipsPipe_props.sv
testbench/mipsPipe_tb.sv

// File: Bender.yml
package:
  name: mipsPipe

sources:
  - target: rtl
    include_dirs:
      - logic
    files:
      - logic/isaPkg.sv
      - logic/pipePkg.sv
      - logic/stageReg.sv
      - logic/regFile.sv
      - logic/execUnit.sv
      - logic/wordMem.sv
      - logic/apbHost.sv
      - logic/pipeControl.sv
      - logic/mipsPipe.sv

  - target: test
    include_dirs:
      - logic
    files:
      - testbench/mipsPipe_props.sv
      - testbench/mipsPipe_tb.sv
